// ==== src/idw_consts.svh ====
// ------------------------------------------------
// AXI read ID width reducer constants
// Widths, remap entry count and per-ID read limit
// ------------------------------------------------

`ifndef IDW_CONSTS_SVH
`define IDW_CONSTS_SVH

// ID width seen by the upstream master on the slave port
`define IDW_SLV_ID_WIDTH 8

// Reduced ID width driven on the master port
`define IDW_MST_ID_WIDTH 2

// One remap entry per master-port ID value
`define IDW_NUM_ENTRIES 4

// Reads that one slave ID may have in flight before AR stalls
`define IDW_MAX_TXNS_PER_ID 4

// Wide enough to hold zero up to the per-ID limit
`define IDW_CNT_WIDTH 3

`define IDW_ADDR_WIDTH 32
`define IDW_DATA_WIDTH 32

`endif

// ==== src/idw_pkg.sv ====
// ------------------------------------------------
// AXI read ID width reducer types
// Vector types shared by the table, counters and top
// ------------------------------------------------

`include "idw_consts.svh"

package idw_pkg;

  // ID as it arrives on AR and leaves on R at the slave port
  typedef logic [`IDW_SLV_ID_WIDTH-1:0] slv_id_t;

  // Reduced ID, which doubles as the index of a remap entry
  typedef logic [`IDW_MST_ID_WIDTH-1:0] mst_id_t;

  typedef logic [`IDW_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`IDW_DATA_WIDTH-1:0] data_t;

  // AXI ARLEN, beats in the burst minus one
  typedef logic [7:0] len_t;

  // AXI RRESP code
  typedef logic [1:0] resp_t;

  // Outstanding read count of one entry
  typedef logic [`IDW_CNT_WIDTH-1:0] txn_cnt_t;

  // One flag per remap entry, bit index equals master ID
  typedef logic [`IDW_NUM_ENTRIES-1:0] entry_vec_t;

endpackage

// ==== src/idw_txn_counters.sv ====
// ------------------------------------------------
// AXI read outstanding counters
// Counts reads in flight per remap entry and flags
// busy and full entries
// ------------------------------------------------

`timescale 1ns/1ps
`include "idw_consts.svh"

module idw_txn_counters
  import idw_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Accepted AR and the entry it uses
  input  logic       alloc_i,
  input  mst_id_t    alloc_idx_i,

  // Master-side R handshake
  input  logic       mst_r_valid_i,
  input  logic       mst_r_ready_i,
  input  logic       mst_r_last_i,
  input  mst_id_t    mst_r_id_i,

  // Entry state back to the table
  output entry_vec_t busy_o,
  output entry_vec_t full_o
);

  // Reads in flight per entry
  txn_cnt_t cnt_q [`IDW_NUM_ENTRIES];

  // Per-entry increment and decrement requests for this cycle
  entry_vec_t inc_vec;
  entry_vec_t dec_vec;

  // A burst is done once its last beat is handed over
  logic       r_done;

  assign r_done = mst_r_valid_i && mst_r_ready_i && mst_r_last_i;

  // Decode the AR and R entry indices into one-hot requests
  always_comb begin
    for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
      inc_vec[i] = alloc_i && (alloc_idx_i == mst_id_t'(i));
      dec_vec[i] = r_done && (mst_r_id_i == mst_id_t'(i));
    end
  end

  // An AR and a last beat on the same entry cancel out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
        case ({inc_vec[i], dec_vec[i]})
          2'b10:   cnt_q[i] <= cnt_q[i] + txn_cnt_t'(1);
          2'b01:   cnt_q[i] <= cnt_q[i] - txn_cnt_t'(1);
          default: cnt_q[i] <= cnt_q[i];
        endcase
      end
    end
  end

  // Flags come straight from the registered counts
  always_comb begin
    for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
      // Entry still owned by its slave ID
      busy_o[i] = (cnt_q[i] != '0);
      // No further AR for this ID until a burst ends
      full_o[i] = (cnt_q[i] == txn_cnt_t'(`IDW_MAX_TXNS_PER_ID));
    end
  end

endmodule

// ==== src/idw_remap_table.sv ====
// ------------------------------------------------
// AXI read ID remap table
// Maps slave IDs onto master IDs on AR, gates the AR
// handshake and restores the slave ID on R
// ------------------------------------------------

`timescale 1ns/1ps
`include "idw_consts.svh"

module idw_remap_table
  import idw_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  // AR from the slave port
  input  logic       slv_ar_valid_i,
  input  slv_id_t    slv_ar_id_i,
  output logic       slv_ar_ready_o,

  // AR towards the master port
  output logic       mst_ar_valid_o,
  output mst_id_t    mst_ar_id_o,
  input  logic       mst_ar_ready_i,

  // R ID lookup
  input  mst_id_t    mst_r_id_i,
  output slv_id_t    slv_r_id_o,

  // Entry state from the counters
  input  entry_vec_t busy_i,
  input  entry_vec_t full_i,

  // Allocation towards the counters
  output logic       alloc_o,
  output mst_id_t    alloc_idx_o
);

  // Slave ID held by each entry, only meaningful while the entry is busy
  slv_id_t ids_q [`IDW_NUM_ENTRIES];

  // Busy entries whose stored ID equals the incoming AR ID
  entry_vec_t match_vec;
  logic       hit;
  mst_id_t    hit_idx;

  // Entries with nothing outstanding
  entry_vec_t free_vec;
  logic       free_any;
  mst_id_t    free_idx;

  // Entry the current AR would use and whether it may proceed
  mst_id_t    sel_idx;
  logic       allowed;
  logic       ar_xfer;

  // Compare the AR ID against every busy entry
  always_comb begin
    for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
      match_vec[i] = busy_i[i] && (ids_q[i] == slv_ar_id_i);
    end
  end

  assign hit = |match_vec;

  // At most one entry can hold a given ID, the priority only keeps the logic defined
  always_comb begin
    hit_idx = '0;
    for (int i = `IDW_NUM_ENTRIES - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        hit_idx = mst_id_t'(i);
      end
    end
  end

  assign free_vec = ~busy_i;
  assign free_any = |free_vec;

  // Lowest-numbered free entry wins
  always_comb begin
    free_idx = '0;
    for (int i = `IDW_NUM_ENTRIES - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_idx = mst_id_t'(i);
      end
    end
  end

  // An ID already in flight keeps its entry, a new ID takes a free one
  assign sel_idx = hit ? hit_idx : free_idx;

  // Stall when the ID's entry is at its limit or a new ID finds no free entry
  assign allowed = hit ? !full_i[hit_idx] : free_any;

  // Both sides of the AR handshake are masked while stalled
  assign mst_ar_valid_o = slv_ar_valid_i && allowed;
  assign slv_ar_ready_o = mst_ar_ready_i && allowed;
  assign mst_ar_id_o    = sel_idx;

  assign ar_xfer = slv_ar_valid_i && mst_ar_ready_i && allowed;

  // Every accepted AR adds one outstanding read to its entry
  assign alloc_o     = ar_xfer;
  assign alloc_idx_o = sel_idx;

  // A new slave ID is stored in the entry it claims when its AR transfers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
        ids_q[i] <= '0;
      end
    end else if (ar_xfer && !hit) begin
      ids_q[free_idx] <= slv_ar_id_i;
    end
  end

  // R carries the master ID, which indexes the entry holding the original ID
  assign slv_r_id_o = ids_q[mst_r_id_i];

endmodule

// ==== src/idw_remap_top.sv ====
// ------------------------------------------------
// AXI read ID width reducer
// Remaps 8-bit slave IDs onto 2-bit master IDs on AR
// and restores them on R
// ------------------------------------------------

`timescale 1ns/1ps
`include "idw_consts.svh"

module idw_remap_top
  import idw_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,

  // Slave port AR
  input  logic    slv_ar_valid_i,
  input  slv_id_t slv_ar_id_i,
  input  addr_t   slv_ar_addr_i,
  input  len_t    slv_ar_len_i,
  output logic    slv_ar_ready_o,

  // Slave port R
  output logic    slv_r_valid_o,
  output slv_id_t slv_r_id_o,
  output data_t   slv_r_data_o,
  output resp_t   slv_r_resp_o,
  output logic    slv_r_last_o,
  input  logic    slv_r_ready_i,

  // Master port AR
  output logic    mst_ar_valid_o,
  output mst_id_t mst_ar_id_o,
  output addr_t   mst_ar_addr_o,
  output len_t    mst_ar_len_o,
  input  logic    mst_ar_ready_i,

  // Master port R
  input  logic    mst_r_valid_i,
  input  mst_id_t mst_r_id_i,
  input  data_t   mst_r_data_i,
  input  resp_t   mst_r_resp_i,
  input  logic    mst_r_last_i,
  output logic    mst_r_ready_o
);

  // Table to counters, one pulse per accepted AR
  logic       alloc;
  mst_id_t    alloc_idx;

  // Counters to table
  entry_vec_t busy;
  entry_vec_t full;

  // Only the ID changes on AR, the rest of the request goes straight through
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;

  // R payload and handshake are untouched apart from the ID
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

  // ID lookup, allocation and AR stall
  idw_remap_table u_table (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_id_i    ( slv_ar_id_i    ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_id_o    ( mst_ar_id_o    ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_id_i     ( mst_r_id_i     ),
    .slv_r_id_o     ( slv_r_id_o     ),
    .busy_i         ( busy           ),
    .full_i         ( full           ),
    .alloc_o        ( alloc          ),
    .alloc_idx_o    ( alloc_idx      )
  );

  // Outstanding reads per entry
  // The counters watch the master-side R beats, so a burst held by
  // slave-side back-pressure keeps its entry until the last beat moves
  idw_txn_counters u_counters (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .alloc_i       ( alloc         ),
    .alloc_idx_i   ( alloc_idx     ),
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_ready_i ( slv_r_ready_i ),
    .mst_r_last_i  ( mst_r_last_i  ),
    .mst_r_id_i    ( mst_r_id_i    ),
    .busy_o        ( busy          ),
    .full_o        ( full          )
  );

endmodule

// ==== test/idw_ref_model.svh ====
// ------------------------------------------------
// Reference model of the read ID remap
// Tracks the slave ID and outstanding reads per entry
// ------------------------------------------------

`ifndef IDW_REF_MODEL_SVH
`define IDW_REF_MODEL_SVH

// Slave ID owned by each entry while its count is not zero
slv_id_t ref_ids [`IDW_NUM_ENTRIES];
int      ref_cnt [`IDW_NUM_ENTRIES];

task automatic clear_model();
  for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
    ref_ids[i] = '0;
    ref_cnt[i] = 0;
  end
endtask

// Entry an AR with this ID would use and whether it may proceed
// A busy entry holding the ID wins over the lowest free entry
task automatic lookup_entry(input slv_id_t id, output mst_id_t idx,
                            output logic allowed, output logic hit);
  logic found;
  found   = 1'b0;
  hit     = 1'b0;
  allowed = 1'b0;
  idx     = '0;
  for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
    if (!found && ref_cnt[i] != 0 && ref_ids[i] == id) begin
      found   = 1'b1;
      hit     = 1'b1;
      idx     = mst_id_t'(i);
      allowed = (ref_cnt[i] < `IDW_MAX_TXNS_PER_ID);
    end
  end
  for (int i = 0; i < `IDW_NUM_ENTRIES; i++) begin
    if (!found && ref_cnt[i] == 0) begin
      found   = 1'b1;
      idx     = mst_id_t'(i);
      allowed = 1'b1;
    end
  end
endtask

// An accepted AR claims a free entry or adds to its own one
task automatic claim_entry(input mst_id_t idx, input slv_id_t id);
  if (ref_cnt[idx] == 0) begin
    ref_ids[idx] = id;
  end
  ref_cnt[idx] = ref_cnt[idx] + 1;
endtask

// The last beat of a burst gives back one read of its entry
task automatic release_entry(input mst_id_t idx);
  ref_cnt[idx] = ref_cnt[idx] - 1;
endtask

`endif

// ==== test/tb_idw_remap.sv ====
// ------------------------------------------------
// Testbench for the AXI read ID width reducer
// Random AR traffic, a master-side R responder and
// a reference model of the remap
// ------------------------------------------------

`timescale 1ns/1ps
`include "idw_consts.svh"

module tb_idw_remap
  import idw_pkg::*;
;

  localparam int NUM_READS     = 300;
  localparam int AR_TIMEOUT    = 1000;
  localparam int DRAIN_TIMEOUT = 4000;

  logic    clk_i;
  logic    rst_n_i;
  logic    slv_ar_valid_i;
  slv_id_t slv_ar_id_i;
  addr_t   slv_ar_addr_i;
  len_t    slv_ar_len_i;
  logic    slv_ar_ready_o;
  logic    slv_r_valid_o;
  slv_id_t slv_r_id_o;
  data_t   slv_r_data_o;
  resp_t   slv_r_resp_o;
  logic    slv_r_last_o;
  logic    slv_r_ready_i;
  logic    mst_ar_valid_o;
  mst_id_t mst_ar_id_o;
  addr_t   mst_ar_addr_o;
  len_t    mst_ar_len_o;
  logic    mst_ar_ready_i;
  logic    mst_r_valid_i;
  mst_id_t mst_r_id_i;
  data_t   mst_r_data_i;
  resp_t   mst_r_resp_i;
  logic    mst_r_last_i;
  logic    mst_r_ready_o;

  integer  seed;
  // Small pool of slave IDs so that entries run out and fill up
  slv_id_t id_pool [6];

  // Next AR to present and whether it still waits for acceptance
  logic    ar_pending;
  slv_id_t ar_id;
  addr_t   ar_addr;
  len_t    ar_len;

  // Entry and length of each accepted burst still owed R beats
  mst_id_t burst_idx_q [$];
  int      burst_len_q [$];

  // Burst being returned and whether the current beat is held
  logic    r_active;
  logic    r_hold;
  mst_id_t r_idx;
  int      r_left;

  int      full_stalls;
  int      nofree_stalls;
  int      reuse_hits;

  `include "idw_ref_model.svh"

  idw_remap_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h", name, exp_val, act_val));
    end
  endtask

  function automatic int rand_range(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Serve any queued burst, but never overtake an older one of the same entry
  task automatic start_burst();
    int k;
    int pos;
    k   = rand_range(burst_idx_q.size());
    pos = k;
    for (int j = 0; j < k; j++) begin
      if (pos == k && burst_idx_q[j] == burst_idx_q[k]) pos = j;
    end
    r_idx    = burst_idx_q[pos];
    r_left   = burst_len_q[pos];
    r_active = 1'b1;
    burst_idx_q.delete(pos);
    burst_len_q.delete(pos);
  endtask

  task automatic drive_inputs();
    slv_ar_valid_i = ar_pending;
    if (ar_pending) begin
      slv_ar_id_i   = ar_id;
      slv_ar_addr_i = ar_addr;
      slv_ar_len_i  = ar_len;
    end
    mst_ar_ready_i = (rand_range(4) != 0);
    slv_r_ready_i  = (rand_range(4) != 0);
    // A beat that was not taken stays on the bus unchanged
    if (!r_hold) begin
      if (!r_active && burst_idx_q.size() > 0 && rand_range(3) == 0) start_burst();
      mst_r_valid_i = r_active;
      mst_r_last_i  = r_active && (r_left == 0);
      if (r_active) begin
        mst_r_id_i   = r_idx;
        mst_r_data_i = $random(seed);
        mst_r_resp_i = resp_t'(rand_range(4));
      end
    end
  endtask

  // Outputs are settled by the falling edge, and the model moves on to the next edge
  task automatic check_outputs();
    mst_id_t exp_idx;
    logic    exp_allowed;
    logic    exp_hit;
    lookup_entry(slv_ar_id_i, exp_idx, exp_allowed, exp_hit);
    compare_value("mst_ar_valid_o", slv_ar_valid_i && exp_allowed, mst_ar_valid_o);
    compare_value("slv_ar_ready_o", mst_ar_ready_i && exp_allowed, slv_ar_ready_o);
    if (slv_ar_valid_i && exp_allowed) begin
      compare_value("mst_ar_id_o", exp_idx, mst_ar_id_o);
      compare_value("mst_ar_addr_o", slv_ar_addr_i, mst_ar_addr_o);
      compare_value("mst_ar_len_o", slv_ar_len_i, mst_ar_len_o);
    end else if (slv_ar_valid_i && exp_hit) begin
      full_stalls++;
    end else if (slv_ar_valid_i) begin
      nofree_stalls++;
    end
    compare_value("slv_r_valid_o", mst_r_valid_i, slv_r_valid_o);
    compare_value("mst_r_ready_o", slv_r_ready_i, mst_r_ready_o);
    if (mst_r_valid_i) begin
      compare_value("slv_r_id_o", ref_ids[mst_r_id_i], slv_r_id_o);
      compare_value("slv_r_data_o", mst_r_data_i, slv_r_data_o);
      compare_value("slv_r_resp_o", mst_r_resp_i, slv_r_resp_o);
      compare_value("slv_r_last_o", mst_r_last_i, slv_r_last_o);
    end
    // Allocation goes first so a same-cycle release on that entry cancels it
    if (slv_ar_valid_i && mst_ar_ready_i && exp_allowed) begin
      claim_entry(exp_idx, slv_ar_id_i);
      burst_idx_q.push_back(exp_idx);
      burst_len_q.push_back(int'(slv_ar_len_i));
      if (exp_hit) reuse_hits++;
      ar_pending = 1'b0;
    end
    if (mst_r_valid_i && slv_r_ready_i) begin
      if (mst_r_last_i) begin
        release_entry(mst_r_id_i);
        r_active = 1'b0;
      end
      r_left = r_left - 1;
      r_hold = 1'b0;
    end else begin
      r_hold = mst_r_valid_i;
    end
  endtask

  task automatic run_cycle();
    @(posedge clk_i);
    #2;
    drive_inputs();
    @(negedge clk_i);
    check_outputs();
  endtask

  initial begin
    int gap;
    int wait_cycles;
    seed           = 10;
    id_pool        = '{8'h03, 8'h17, 8'h2a, 8'h5c, 8'h81, 8'hf0};
    rst_n_i        = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    ar_pending     = 1'b0;
    ar_id          = id_pool[0];
    r_active       = 1'b0;
    r_hold         = 1'b0;
    full_stalls    = 0;
    nofree_stalls  = 0;
    reuse_hits     = 0;
    clear_model();
    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    // Idle bus straight out of reset
    @(negedge clk_i);
    compare_value("mst_ar_valid_o", 1'b0, mst_ar_valid_o);
    compare_value("slv_r_valid_o", 1'b0, slv_r_valid_o);
    for (int n = 0; n < NUM_READS; n++) begin
      gap = rand_range(3);
      for (int g = 0; g < gap; g++) run_cycle();
      // Repeating the last ID half the time drives entries to their limit
      if (rand_range(2) != 0) ar_id = id_pool[rand_range(6)];
      ar_addr     = $random(seed);
      ar_len      = len_t'(rand_range(4));
      ar_pending  = 1'b1;
      wait_cycles = 0;
      while (ar_pending) begin
        if (wait_cycles == AR_TIMEOUT) begin
          abort_run($sformatf("AR with slave ID 0x%0h was never accepted", ar_id));
        end else begin
          run_cycle();
          wait_cycles++;
        end
      end
    end
    wait_cycles = 0;
    while (burst_idx_q.size() != 0 || r_active) begin
      if (wait_cycles == DRAIN_TIMEOUT) begin
        abort_run("R bursts of accepted reads never finished on the slave side");
      end else begin
        run_cycle();
        wait_cycles++;
      end
    end
    run_cycle();
    if (full_stalls > 0 && nofree_stalls > 0 && reuse_hits > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run($sformatf("Stall or reuse case never seen: full %0d, no free %0d, reuse %0d",
                          full_stalls, nofree_stalls, reuse_hits));
    end
  end

endmodule

// ==== verilog.f ====
+incdir+src
+incdir+test
src/idw_pkg.sv
src/idw_txn_counters.sv
src/idw_remap_table.sv
src/idw_remap_top.sv
test/tb_idw_remap.sv
